// File: arrayAllocator.sv
// Array handle allocator
// LIFO of freed handles, live flag per array and high-water count
`timescale 1ns/10ps
`include "heap_config.svh"

module arrayAllocator
  import heapPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    allocRequest,
  input  logic    freeRequest,
  input  logic    clearAll,
  input  arrayIdT freeArray,
  output arrayIdT allocArray,
  output logic    allocOk,
  input  arrayIdT queryArray,
  output logic    queryAllocated,
  output logic    queryLive
);

  localparam int ArrayCount = 1 << `HEAP_ARRAY_BITS;

  arrayIdT                freedStack [ArrayCount];   // Freed handles, newest on top
  arrayCountT             freedTop;                  // Entries on the stack
  arrayCountT             highWater;                 // Handles ever handed out
  logic [ArrayCount-1:0]  live;                      // Currently allocated arrays

  // ------------------------------------------------------------------
  // Answers for the current command
  // ------------------------------------------------------------------
  assign allocOk = (freedTop != '0) || (highWater < arrayCountT'(ArrayCount));

  // Most recently freed handle first, then a fresh one
  assign allocArray = (freedTop != '0) ? freedStack[arrayIdT'(freedTop - 1'b1)]
                                       : arrayIdT'(highWater);

  assign queryAllocated = {1'b0, queryArray} < highWater;
  assign queryLive      = live[queryArray];

  // ------------------------------------------------------------------
  // Allocation state
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freedTop  <= '0;
      highWater <= '0;
      live      <= '0;
    end else if (clearAll) begin                     // Forget every array
      freedTop  <= '0;
      highWater <= '0;
      live      <= '0;
    end else if (allocRequest && allocOk) begin
      if (freedTop != '0) begin
        freedTop <= freedTop - 1'b1;                 // Reuse a freed handle
      end else begin
        highWater <= highWater + 1'b1;               // Take a new handle
      end
      live[allocArray] <= 1'b1;
    end else if (freeRequest) begin
      live[freeArray] <= 1'b0;                       // Mark the freed array itself
      freedTop        <= freedTop + 1'b1;
    end
  end

  // Only live arrays are freed, so the stack never overflows
  always_ff @(posedge clock) begin
    if (freeRequest && !clearAll && !allocRequest) begin
      freedStack[arrayIdT'(freedTop)] <= freeArray;
    end
  end

endmodule

// File: flist.f
+incdir+.
heapPkg.sv
arrayAllocator.sv
heapEngine.sv
responseQueue.sv
responseSender.sv
heapUnit.sv
tbClock.sv
responseChecker.sv
heapUnitTb.sv

// File: heapEngine.sv
// Heap command engine
// Holds element storage and sizes, checks each command against the
// allocator and produces one response per accepted command
`timescale 1ns/10ps
`include "heap_config.svh"

module heapEngine
  import heapPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         commandValid,
  input  heapCommandT  command,
  output logic         commandReady,
  output logic         allocRequest,
  output logic         freeRequest,
  output logic         clearAll,
  output arrayIdT      freeArray,
  input  arrayIdT      allocArray,
  input  logic         allocOk,
  input  logic         queryAllocated,
  input  logic         queryLive,
  output logic         pushValid,
  output heapResponseT pushResponse,
  input  slotCountT    freeSlots
);

  localparam int ArrayCount  = 1 << `HEAP_ARRAY_BITS;
  localparam int ArrayLength = 1 << `HEAP_INDEX_BITS;

  dataT        memory [ArrayCount][ArrayLength];  // Fixed block per array
  sizeT        arraySizes [ArrayCount];
  engineStateT state;                             // Busy clears sizes after Reset

  logic        accept, writable, readable, okay;
  sizeT        curSize, indexHit;
  dataT        element, result;
  heapStatusT  status, checkStatus;
  logic        memWrite, sizeWrite;
  indexT       memIndex;
  dataT        memData;
  arrayIdT     sizeArray;
  sizeT        sizeValue;

  assign commandReady = freeSlots != '0;          // Room for the response
  assign accept       = commandValid && commandReady;
  assign freeArray    = command.array;

  assign curSize  = arraySizes[command.array];
  assign element  = memory[command.array][command.index];
  assign writable = queryAllocated && queryLive;
  assign readable = writable && ({1'b0, command.index} < curSize);

  always_comb begin
    if (!queryAllocated) checkStatus = statusNotAllocated;
    else if (!queryLive) checkStatus = statusFreed;
    else                 checkStatus = statusOutOfBounds;
  end

  always_comb begin                               // Highest matching position
    indexHit = '0;
    for (int i = 0; i < ArrayLength; i++) begin
      if (sizeT'(i) < curSize && memory[command.array][i] == command.data) begin
        indexHit = sizeT'(i + 1);
      end
    end
  end

  // ------------------------------------------------------------------
  // Command decode
  // ------------------------------------------------------------------
  always_comb begin
    status    = statusOk;
    result    = '0;
    memWrite  = 1'b0;
    memIndex  = command.index;
    memData   = command.data;
    sizeWrite = 1'b0;
    sizeArray = command.array;
    sizeValue = curSize;
    case (command.op)
      opAlloc: begin
        if (allocOk) begin
          result    = dataT'(allocArray);         // New handle, empty array
          sizeWrite = 1'b1;
          sizeArray = allocArray;
          sizeValue = '0;
        end else status = statusOutOfMemory;
      end
      opFree:  if (!writable) status = checkStatus;
      opWrite: begin
        if (!writable) status = checkStatus;
        result    = command.data;
        memWrite  = 1'b1;
        sizeWrite = {1'b0, command.index} >= curSize;   // Extend to index plus one
        sizeValue = {1'b0, command.index} + 1'b1;
      end
      opRead: begin
        if (!readable) status = checkStatus;
        result = element;
      end
      opSize: begin
        if (!writable) status = checkStatus;
        result = dataT'(curSize);
      end
      opPush: begin
        if (!writable) status = checkStatus;
        else if (curSize == sizeT'(ArrayLength)) status = statusFull;
        result    = command.data;                 // Echo the pushed value
        memWrite  = 1'b1;
        memIndex  = indexT'(curSize);
        sizeWrite = 1'b1;
        sizeValue = curSize + 1'b1;
      end
      opPop: begin
        if (!writable) status = checkStatus;
        else if (curSize == '0) status = statusEmpty;
        result    = memory[command.array][indexT'(curSize - 1'b1)];
        sizeWrite = 1'b1;
        sizeValue = curSize - 1'b1;
      end
      opIndex: begin
        if (!writable) status = checkStatus;
        result = dataT'(indexHit);
      end
      opAdd: begin
        if (!readable) status = checkStatus;
        result   = element + command.data;        // Wraps at 12 bits
        memData  = result;
        memWrite = 1'b1;
      end
      default: result = '0;                       // Reset and unused codes
    endcase
    if (status != statusOk) result = '0;
  end

  assign okay         = accept && (status == statusOk);
  assign clearAll     = okay && (command.op == opReset);
  assign allocRequest = okay && (command.op == opAlloc);
  assign freeRequest  = okay && (command.op == opFree);

  assign pushValid    = accept;
  assign pushResponse = '{data: result, status: status};

  // ------------------------------------------------------------------
  // Storage update
  // ------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (okay && memWrite) memory[command.array][memIndex] <= memData;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= stateIdle;
      for (int a = 0; a < ArrayCount; a++) arraySizes[a] <= '0;
    end else begin
      state <= clearAll ? stateBusy : stateIdle;
      if (state == stateBusy) begin               // Sweep after a Reset command
        for (int a = 0; a < ArrayCount; a++) arraySizes[a] <= '0;
      end
      if (okay && sizeWrite) arraySizes[sizeArray] <= sizeValue;
    end
  end

endmodule

// File: heapPkg.sv
// Heap memory unit types
// Width typedefs, opcode and status encodings, command and response records
`include "heap_config.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;           // Array handle
  typedef logic [`HEAP_ARRAY_BITS:0] arrayCountT;          // Count of handles, 0 to 4
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;             // Element position
  typedef logic [`HEAP_INDEX_BITS:0] sizeT;                // Array size, 0 to 8
  typedef logic [`HEAP_DATA_BITS-1:0] dataT;               // Element or result word
  typedef logic [$clog2(`HEAP_QUEUE_DEPTH+1)-1:0] slotCountT;   // Queue occupancy
  typedef logic [$clog2(`HEAP_MAX_CREDITS+1)-1:0] creditCountT; // Credits held

  typedef enum logic [3:0] {
    opReset = 4'd0,
    opAlloc = 4'd1,
    opFree  = 4'd2,
    opWrite = 4'd3,
    opRead  = 4'd4,
    opSize  = 4'd5,
    opPush  = 4'd6,
    opPop   = 4'd7,
    opIndex = 4'd8,
    opAdd   = 4'd9
  } heapOpT;

  typedef enum logic [2:0] {
    statusOk           = 3'd0,
    statusNotAllocated = 3'd1,  // Handle at or above high water
    statusFreed        = 3'd2,
    statusOutOfBounds  = 3'd3,  // Index at or above array size
    statusFull         = 3'd4,
    statusEmpty        = 3'd5,
    statusOutOfMemory  = 3'd6
  } heapStatusT;

  typedef struct packed {
    heapOpT  op;
    arrayIdT array;
    indexT   index;
    dataT    data;
  } heapCommandT;

  typedef struct packed {
    dataT       data;
    heapStatusT status;
  } heapResponseT;

  typedef enum logic {stateIdle, stateBusy} engineStateT;

endpackage

// File: heapUnit.sv
// Heap memory unit top level
// Command engine feeds the response queue, which the credit sender drains
`timescale 1ns/10ps

module heapUnit
  import heapPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         commandValid,
  input  heapCommandT  command,
  output logic         commandReady,
  output logic         responseValid,
  output heapResponseT response,
  input  logic         responseCredit
);

  logic         allocRequest, freeRequest, clearAll, allocOk;
  logic         queryAllocated, queryLive;
  arrayIdT      freeArray, allocArray;
  logic         pushValid, notEmpty, pop;
  heapResponseT pushResponse, head;
  slotCountT    freeSlots;

  heapEngine engine0 (
    .clock, .resetN, .commandValid, .command, .commandReady,
    .allocRequest, .freeRequest, .clearAll, .freeArray,
    .allocArray, .allocOk, .queryAllocated, .queryLive,
    .pushValid, .pushResponse, .freeSlots
  );

  arrayAllocator allocator0 (
    .clock, .resetN, .allocRequest, .freeRequest, .clearAll, .freeArray,
    .allocArray, .allocOk, .queryArray(command.array), .queryAllocated, .queryLive
  );

  responseQueue queue0 (
    .clock, .resetN, .pushValid, .pushResponse, .pop, .notEmpty, .head, .freeSlots
  );

  responseSender sender0 (
    .clock, .resetN, .responseCredit, .notEmpty, .head, .pop, .responseValid, .response
  );

endmodule

// File: heapUnitTb.sv
// Heap unit testbench top
// Drives commands from the data file and grants response credits at random
`timescale 1ns/10ps

module heapUnitTb;
  import heapPkg::*;

  localparam int ReadyLimit    = 200;        // Cycles to wait for commandReady
  localparam int ResetLimit    = 40;
  localparam int ResponseLimit = 2000;

  logic         clock, resetN;
  logic         commandValid, commandReady, responseValid;
  logic         responseCredit = 1'b0;
  heapCommandT  command;
  heapResponseT response;
  heapCommandT  commands [$];

  int     expectedCount, receivedCount, mismatchCount, extraCount, checkFileErrors;
  int     creditErrors, otherErrors, missing, total;
  int     cycleCount = 0;
  integer seed = 15;
  logic   stopSending;

  tbClock clock0 (.clock, .resetN);

  heapUnit dut0 (
    .clock, .resetN, .commandValid, .command, .commandReady,
    .responseValid, .response, .responseCredit
  );

  responseChecker checker0 (
    .clock, .resetN, .responseValid, .response, .responseCredit, .expectedCount,
    .receivedCount, .mismatchCount, .extraCount, .creditErrors,
    .fileErrors(checkFileErrors)
  );

  // ------------------------------------------------------------------
  // Credits withheld for 40 of every 64 cycles and granted at random otherwise
  // ------------------------------------------------------------------
  always @(posedge clock) begin
    #1;
    cycleCount = cycleCount + 1;
    if (!resetN || (cycleCount % 64) < 40) responseCredit = 1'b0;
    else responseCredit = ($random(seed) & 1) == 1;
  end

  task automatic readCommands();
    int    fd, chars, op, arr, idx, dat, eData, eStat;
    string line;
    fd = $fopen("heap_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open heap_input.txt to read the commands");
      otherErrors++;
      return;
    end
    while (!$feof(fd)) begin
      chars = $fgets(line, fd);
      if (chars > 0 &&
          $sscanf(line, "%h %h %h %h %h %h", op, arr, idx, dat, eData, eStat) == 6) begin
        commands.push_back('{op: heapOpT'(op[3:0]), array: arrayIdT'(arr),
                             index: indexT'(idx), data: dataT'(dat)});
      end
    end
    $fclose(fd);
  endtask

  task automatic waitForReset();
    int n;
    for (n = 0; n < ResetLimit && !resetN; n++) @(posedge clock);
    if (!resetN) begin
      $display("Reset was never released");
      otherErrors++;
      stopSending = 1'b1;
    end
    @(posedge clock);
    #1;
  endtask

  // Holds the command until commandReady is seen before an edge
  task automatic sendCommand(input heapCommandT cmd);
    int   tries;
    logic accepted;
    command      = cmd;
    commandValid = 1'b1;
    accepted     = 1'b0;
    for (tries = 0; tries < ReadyLimit && !accepted; tries++) begin
      @(negedge clock);
      accepted = commandReady;
      @(posedge clock);
      #1;
    end
    if (!accepted) begin
      $display("commandReady stayed low for %0d cycles, sending stopped", ReadyLimit);
      otherErrors++;
      stopSending = 1'b1;
    end
  endtask

  task automatic waitForResponses();
    int n;
    for (n = 0; n < ResponseLimit && receivedCount < expectedCount; n++) @(posedge clock);
    if (receivedCount < expectedCount) begin
      $display("Timed out with %0d of %0d responses received", receivedCount, expectedCount);
      otherErrors++;
    end
  endtask

  initial begin
    commandValid = 1'b0;
    command      = '0;
    otherErrors  = 0;
    stopSending  = 1'b0;
    readCommands();
    if (commands.size() == 0) begin
      $display("The data file holds no commands");
      otherErrors++;
    end
    waitForReset();
    foreach (commands[i]) begin
      if (!stopSending) sendCommand(commands[i]);
    end
    commandValid = 1'b0;
    waitForResponses();
    repeat (16) @(posedge clock);                // Catch any extra responses
    missing = expectedCount - receivedCount;
    total   = mismatchCount + missing + extraCount + creditErrors + otherErrors +
              checkFileErrors;
    $display("Errors: %0d mismatch, %0d missing, %0d extra, %0d credit, %0d other",
             mismatchCount, missing, extraCount, creditErrors,
             otherErrors + checkFileErrors);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: heap_config.svh
// Heap memory unit configuration
// Array geometry, element width, response queue depth and credit limit
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// Array handle bits, four arrays
`define HEAP_ARRAY_BITS 2

// Element index bits, eight elements per array
`define HEAP_INDEX_BITS 3

`define HEAP_DATA_BITS 12    // Element and result width

`define HEAP_QUEUE_DEPTH 4   // Response queue entries

`define HEAP_MAX_CREDITS 7   // Largest credit count held by the sender

`endif

// File: heap_input.txt
// Columns op array index data expectedData expectedStatus in hex
// Status codes 0 ok 1 notAllocated 2 freed 3 outOfBounds 4 full 5 empty 6 outOfMemory
1 0 0 000 000 0
1 0 0 000 001 0
1 0 0 000 002 0
1 0 0 000 003 0
1 0 0 000 000 6
3 0 2 123 123 0
4 0 2 000 123 0
5 0 0 000 003 0
9 0 2 f00 023 0
4 0 2 000 023 0
4 0 3 000 000 3
9 0 5 001 000 3
6 1 0 011 011 0
6 1 0 022 022 0
6 1 0 033 033 0
6 1 0 044 044 0
6 1 0 055 055 0
6 1 0 066 066 0
6 1 0 077 077 0
6 1 0 088 088 0
6 1 0 099 000 4
5 1 0 000 008 0
3 1 5 022 022 0
8 1 0 022 006 0
8 1 0 0ab 000 0
7 1 0 000 088 0
7 1 0 000 077 0
7 1 0 000 022 0
7 1 0 000 055 0
7 1 0 000 044 0
7 1 0 000 033 0
7 1 0 000 022 0
7 1 0 000 011 0
7 1 0 000 000 5
2 2 0 000 000 0
4 2 0 000 000 2
2 2 0 000 000 2
1 0 0 000 002 0
5 2 0 000 000 0
0 0 0 000 000 0
4 0 0 000 000 1
1 0 0 000 000 0
6 0 0 5a5 5a5 0
7 0 0 000 5a5 0
3 1 0 001 000 1
1 0 0 000 001 0
2 0 0 000 000 0
2 1 0 000 000 0
1 0 0 000 001 0
1 0 0 000 000 0
1 0 0 000 002 0
7 2 0 000 000 5
2 3 0 000 000 1

// File: responseChecker.sv
// Heap unit response checker
// Compares each response with the expected data and status from the data file
`timescale 1ns/10ps

module responseChecker
  import heapPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         responseValid,
  input  heapResponseT response,
  input  logic         responseCredit,
  output int           expectedCount,
  output int           receivedCount,
  output int           mismatchCount,
  output int           extraCount,
  output int           creditErrors,
  output int           fileErrors
);

  dataT       expData [$];                       // Expected results in command order
  heapStatusT expStatus [$];
  int         creditsGranted;                    // Credit pulses seen so far

  initial begin
    int    fd, chars, op, arr, idx, dat, eData, eStat;
    string line;
    fileErrors = 0;
    fd = $fopen("heap_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open heap_input.txt to read the expected responses");
      fileErrors = 1;
    end else begin
      while (!$feof(fd)) begin
        chars = $fgets(line, fd);
        if (chars > 0 &&
            $sscanf(line, "%h %h %h %h %h %h", op, arr, idx, dat, eData, eStat) == 6) begin
          expData.push_back(dataT'(eData));
          expStatus.push_back(heapStatusT'(eStat[2:0]));
        end
      end
      $fclose(fd);
    end
    expectedCount = expData.size();
  end

  // ------------------------------------------------------------------
  // Sample at the falling edge where outputs are settled
  // ------------------------------------------------------------------
  always @(negedge clock) begin
    if (!resetN) begin
      receivedCount  = 0;
      mismatchCount  = 0;
      extraCount     = 0;
      creditErrors   = 0;
      creditsGranted = 0;
    end else begin
      if (responseValid) begin
        if (receivedCount + extraCount >= creditsGranted) begin
          $display("Response %0d was sent with no credit granted for it",
                   receivedCount + extraCount);
          creditErrors = creditErrors + 1;
        end
        if (receivedCount >= expectedCount) begin
          $display("Response arrived after the last expected one, data %03h", response.data);
          extraCount = extraCount + 1;
        end else begin
          if (response.data !== expData[receivedCount]) begin
            $display("Mismatch response.data #%0d: expected %03h, got %03h",
                     receivedCount, expData[receivedCount], response.data);
            mismatchCount = mismatchCount + 1;
          end
          if (response.status !== expStatus[receivedCount]) begin
            $display("Mismatch response.status #%0d: expected %0h, got %0h",
                     receivedCount, expStatus[receivedCount], response.status);
            mismatchCount = mismatchCount + 1;
          end
          receivedCount = receivedCount + 1;
        end
      end
      if (responseCredit) creditsGranted = creditsGranted + 1;   // Spendable from next edge
    end
  end

endmodule

// File: responseQueue.sv
// Response queue
// Synchronous FIFO between the engine and the sender, reports free slots
`timescale 1ns/10ps
`include "heap_config.svh"

module responseQueue
  import heapPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         pushValid,
  input  heapResponseT pushResponse,
  input  logic         pop,
  output logic         notEmpty,
  output heapResponseT head,
  output slotCountT    freeSlots
);

  localparam int Depth   = `HEAP_QUEUE_DEPTH;
  localparam int PtrBits = $clog2(Depth);

  heapResponseT       entries [Depth];
  logic [PtrBits-1:0] readPtr, writePtr;
  slotCountT          count;
  logic               doPush, doPop;

  assign notEmpty  = count != '0;
  assign head      = entries[readPtr];
  assign freeSlots = slotCountT'(Depth) - count;
  assign doPush    = pushValid && (count != slotCountT'(Depth));  // Drop only if full
  assign doPop     = pop && notEmpty;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      readPtr  <= '0;
      writePtr <= '0;
      count    <= '0;
    end else begin
      if (doPush) begin
        writePtr <= (writePtr == PtrBits'(Depth - 1)) ? '0 : writePtr + 1'b1;
      end
      if (doPop) begin
        readPtr <= (readPtr == PtrBits'(Depth - 1)) ? '0 : readPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (doPush) entries[writePtr] <= pushResponse;
  end

endmodule

// File: responseSender.sv
// Credit driven response sender
// Spends one credit per response taken from the queue head
`timescale 1ns/10ps
`include "heap_config.svh"

module responseSender
  import heapPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         responseCredit,
  input  logic         notEmpty,
  input  heapResponseT head,
  output logic         pop,
  output logic         responseValid,
  output heapResponseT response
);

  creditCountT credits;                 // Zero after reset
  logic        grant;

  assign pop   = (credits != '0) && notEmpty;
  // Saturate at the limit unless a credit is spent in the same cycle
  assign grant = responseCredit &&
                 ((credits != creditCountT'(`HEAP_MAX_CREDITS)) || pop);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      credits       <= '0;
      responseValid <= 1'b0;
    end else begin
      responseValid <= pop;             // One cycle pulse per response
      case ({grant, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pop) response <= head;
  end

endmodule

// File: run.sh
#!/bin/bash
# Build the heap unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module heapUnitTb -f flist.f \
  -o heapSim > build.log 2>&1 \
  && ./obj_dir/heapSim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

// File: tbClock.sv
// Testbench clock and reset
// 40 ns clock, active low reset held for the first 10 cycles
`timescale 1ns/10ps

module tbClock (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;              // 40 ns period
  end

  initial begin
    resetN = 1'b0;
    repeat (10) @(posedge clock);
    #1 resetN = 1'b1;                       // Release just after an edge
  end

endmodule
